// File: kdi_pkg.sv
/*
 * Shared widths, digest command and selector encodings, and the request
 * bundle of the scrambling-key derivation unit
 */
package kdi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // One digest block
  localparam int BlockWidth = 64;
  // Derived key, two digest blocks
  localparam int KeyWidth = 128;
  // Key seed, four digest blocks
  localparam int SeedWidth = 256;
  // Entropy word, same size as one block
  localparam int EdnWidth = 64;
  // Nonce register size in entropy words
  localparam int NonceWords = 2;
  localparam int NonceWidth = NonceWords * EdnWidth;
  // Flash data, flash address and SRAM requesters
  localparam int NumReq = 3;
  localparam int ReqIdxWidth = $clog2(NumReq);
  // Seed block and entropy word counters
  localparam int CntWidth = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Command to the digest engine
  typedef enum logic [1:0] {
    DigestInit,
    LoadShadow,
    Digest,
    DigestFinalize
  } kdi_cmd_e;

  // Selects the digest constants inside the engine
  typedef enum logic [1:0] {
    FlashDataKey,
    FlashAddrKey,
    SramDataKey
  } kdi_sel_e;

  // Everything the FSM and datapath need to know about one request
  typedef struct packed {
    // Mix two entropy words into each key half
    logic                                  ingest_entropy;
    kdi_sel_e                              digest_sel;
    // Index of the last nonce word to fetch
    logic [CntWidth-1:0]                   nonce_last;
    // Seed is forced to zero when this is low
    logic                                  seed_valid;
    logic [SeedWidth/BlockWidth-1:0][BlockWidth-1:0] seed;
  } kdi_req_cfg_t;

endpackage

// File: kdi_ctrl_if.sv
/*
 * Control bundle between the derivation FSM and the datapath.
 * The FSM drives enables and clears, the datapath returns its counters
 */
`timescale 1ns/1ns

interface kdi_ctrl_if;

  // Seed block counter
  logic                         seed_clr;
  logic                         seed_inc;
  // Entropy and nonce word counter
  logic                         ent_clr;
  logic                         ent_inc;
  // Output register enables
  logic                         key_en;
  logic                         nonce_en;
  logic                         seed_valid_en;
  // Digest data comes from the entropy words instead of the seed
  logic                         sel_entropy;
  // Counter values back from the datapath
  logic [kdi_pkg::CntWidth-1:0] seed_cnt;
  logic [kdi_pkg::CntWidth-1:0] ent_cnt;

  modport fsm (
    output seed_clr, seed_inc, ent_clr, ent_inc,
    output key_en, nonce_en, seed_valid_en, sel_entropy,
    input  seed_cnt, ent_cnt
  );

  modport dp (
    input  seed_clr, seed_inc, ent_clr, ent_inc,
    input  key_en, nonce_en, seed_valid_en, sel_entropy,
    output seed_cnt, ent_cnt
  );

endinterface

// File: kdi_req_arb.sv
/*
 * Round-robin arbiter with a locked grant. The winner's payload is
 * forwarded until the consumer signals ready, which pulses the grant
 */
`timescale 1ns/1ns

module kdi_req_arb #(
  parameter type T = logic
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [kdi_pkg::NumReq-1:0] req_i,
  input  T                           cfg_i [kdi_pkg::NumReq],
  output logic [kdi_pkg::NumReq-1:0] gnt_o,
  output logic                       valid_o,
  output T                           cfg_o,
  input  logic                       ready_i
);

  logic [kdi_pkg::ReqIdxWidth-1:0] ptr_q;
  logic [kdi_pkg::ReqIdxWidth-1:0] idx_q;
  logic [kdi_pkg::ReqIdxWidth-1:0] win_idx;
  logic [kdi_pkg::ReqIdxWidth-1:0] cur_idx;
  logic                            lock_q;

  // Search upward from the pointer, wrapping at NumReq
  always_comb begin : p_search
    int  cand;
    logic found;
    win_idx = ptr_q;
    found   = 1'b0;
    for (int i = 0; i < kdi_pkg::NumReq; i++) begin
      cand = int'(ptr_q) + i;
      if (cand >= kdi_pkg::NumReq) begin
        cand = cand - kdi_pkg::NumReq;
      end
      if (!found && req_i[cand]) begin
        win_idx = kdi_pkg::ReqIdxWidth'(cand);
        found   = 1'b1;
      end
    end
  end

  // Once chosen, the grant stays put until ready
  assign cur_idx = lock_q ? idx_q : win_idx;
  assign valid_o = lock_q | (|req_i);
  assign cfg_o   = cfg_i[cur_idx];

  always_comb begin
    gnt_o = '0;
    if (ready_i) begin
      gnt_o[cur_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q  <= '0;
      idx_q  <= '0;
      lock_q <= 1'b0;
    end else if (ready_i) begin
      lock_q <= 1'b0;
      // Next search starts just above the served requester
      if (int'(cur_idx) == kdi_pkg::NumReq - 1) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= cur_idx + 1'b1;
      end
    end else if (!lock_q && valid_o) begin
      lock_q <= 1'b1;
      idx_q  <= win_idx;
    end
  end

endmodule

// File: kdi_datapath.sv
/*
 * Seed and entropy counters, key, nonce and seed-valid output registers,
 * and the block mux feeding the digest engine
 */
`timescale 1ns/1ns

module kdi_datapath (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  kdi_ctrl_if.dp                          ctrl,
  input  kdi_pkg::kdi_req_cfg_t           cfg_i,
  input  logic [kdi_pkg::EdnWidth-1:0]    edn_data_i,
  input  logic [kdi_pkg::BlockWidth-1:0]  scrmbl_rsp_data_i,
  output logic [kdi_pkg::BlockWidth-1:0]  scrmbl_data_o,
  output logic [kdi_pkg::KeyWidth-1:0]    key_o,
  output logic [kdi_pkg::NonceWidth-1:0]  nonce_o,
  output logic                            seed_valid_o
);

  logic [kdi_pkg::CntWidth-1:0] seed_cnt_q;
  logic [kdi_pkg::CntWidth-1:0] ent_cnt_q;
  logic [kdi_pkg::KeyWidth/kdi_pkg::BlockWidth-1:0][kdi_pkg::BlockWidth-1:0] key_q;
  logic [kdi_pkg::NonceWords-1:0][kdi_pkg::EdnWidth-1:0] nonce_q;
  logic seed_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seed_cnt_q <= '0;
      ent_cnt_q  <= '0;
    end else begin
      if (ctrl.seed_clr) begin
        seed_cnt_q <= '0;
      end else if (ctrl.seed_inc) begin
        seed_cnt_q <= seed_cnt_q + 1'b1;
      end
      if (ctrl.ent_clr) begin
        ent_cnt_q <= '0;
      end else if (ctrl.ent_inc) begin
        ent_cnt_q <= ent_cnt_q + 1'b1;
      end
    end
  end

  assign ctrl.seed_cnt = seed_cnt_q;
  assign ctrl.ent_cnt  = ent_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q        <= '0;
      nonce_q      <= '0;
      seed_valid_q <= 1'b0;
    end else begin
      // Upper seed bit tells which key half the digest belongs to
      if (ctrl.key_en) begin
        key_q[seed_cnt_q[1]] <= scrmbl_rsp_data_i;
      end
      // Also parks the entropy words ingested for the SRAM key
      if (ctrl.nonce_en) begin
        nonce_q[ent_cnt_q[0]] <= edn_data_i;
      end
      if (ctrl.seed_valid_en) begin
        seed_valid_q <= cfg_i.seed_valid;
      end
    end
  end

  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Digest data mux
  ////////////////////////////////////////////////////////////////////////////

  // An invalid seed goes out as zero
  always_comb begin
    if (ctrl.sel_entropy) begin
      scrmbl_data_o = nonce_q[ent_cnt_q[0]];
    end else if (cfg_i.seed_valid) begin
      scrmbl_data_o = cfg_i.seed[seed_cnt_q];
    end else begin
      scrmbl_data_o = '0;
    end
  end

endmodule

// File: kdi_ctrl_fsm.sv
/*
 * Derivation sequencing FSM. Drives the digest engine, entropy fetches
 * and the datapath controls, and acks the arbiter when a key is ready
 */
`timescale 1ns/1ns

module kdi_ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  kdi_en_i,
  input  logic                  escalate_i,
  // Arbitrated request
  input  logic                  valid_i,
  input  kdi_pkg::kdi_req_cfg_t cfg_i,
  output logic                  ready_o,
  kdi_ctrl_if.fsm               ctrl,
  // Entropy source
  input  logic                  edn_ack_i,
  output logic                  edn_req_o,
  // Digest engine mutex
  input  logic                  mtx_gnt_i,
  output logic                  mtx_req_o,
  // Digest engine
  input  logic                  scrmbl_ready_i,
  input  logic                  scrmbl_rsp_valid_i,
  output logic                  scrmbl_valid_o,
  output kdi_pkg::kdi_cmd_e     scrmbl_cmd_o,
  output kdi_pkg::kdi_sel_e     scrmbl_sel_o,
  output logic                  fsm_err_o
);

  typedef enum logic [3:0] {
    ResetSt,
    IdleSt,
    ClrSt,
    LoadSt,
    FetchEntSt,
    LoadEntSt,
    FinSt,
    WaitSt,
    FetchNonceSt,
    FinishSt,
    ErrorSt
  } state_e;

  state_e state_d, state_q;
  logic   edn_req_d, edn_req_q;

  assign edn_req_o    = edn_req_q;
  assign scrmbl_sel_o = cfg_i.digest_sel;

  always_comb begin : p_fsm
    state_d   = state_q;
    fsm_err_o = 1'b0;
    ready_o   = 1'b0;
    // An open entropy request survives until acked, even into error
    edn_req_d = edn_req_q & ~edn_ack_i;

    ctrl.seed_clr      = 1'b0;
    ctrl.seed_inc      = 1'b0;
    ctrl.ent_clr       = 1'b0;
    ctrl.ent_inc       = 1'b0;
    ctrl.key_en        = 1'b0;
    ctrl.nonce_en      = 1'b0;
    ctrl.seed_valid_en = 1'b0;
    ctrl.sel_entropy   = 1'b0;

    mtx_req_o      = 1'b0;
    scrmbl_valid_o = 1'b0;
    scrmbl_cmd_o   = kdi_pkg::LoadShadow;

    unique case (state_q)
      // Wait for enable after the OTP partitions come up
      ResetSt: begin
        if (kdi_en_i) begin
          state_d = IdleSt;
        end
      end
      IdleSt: begin
        if (valid_i) begin
          state_d       = ClrSt;
          ctrl.seed_clr = 1'b1;
          ctrl.ent_clr  = 1'b1;
        end
      end
      // Revert the digest to its IV, only once the mutex is ours
      ClrSt: begin
        mtx_req_o      = 1'b1;
        scrmbl_valid_o = mtx_gnt_i;
        scrmbl_cmd_o   = kdi_pkg::DigestInit;
        if (mtx_gnt_i && scrmbl_ready_i) begin
          state_d = LoadSt;
        end
      end
      // Even block is shadow-loaded, odd block triggers the digest
      LoadSt: begin
        mtx_req_o      = 1'b1;
        scrmbl_valid_o = 1'b1;
        if (ctrl.seed_cnt[0]) begin
          scrmbl_cmd_o = kdi_pkg::Digest;
          if (scrmbl_ready_i) begin
            state_d = cfg_i.ingest_entropy ? FetchEntSt : FinSt;
          end
        end else if (scrmbl_ready_i) begin
          ctrl.seed_inc = 1'b1;
        end
      end
      // Two fresh words for this key half
      FetchEntSt: begin
        mtx_req_o = 1'b1;
        edn_req_d = 1'b1;
        if (edn_ack_i) begin
          ctrl.nonce_en = 1'b1;
          if (ctrl.ent_cnt == 2'd1) begin
            edn_req_d    = 1'b0;
            ctrl.ent_clr = 1'b1;
            state_d      = LoadEntSt;
          end else begin
            ctrl.ent_inc = 1'b1;
          end
        end
      end
      LoadEntSt: begin
        mtx_req_o        = 1'b1;
        ctrl.sel_entropy = 1'b1;
        scrmbl_valid_o   = 1'b1;
        if (ctrl.ent_cnt[0]) begin
          scrmbl_cmd_o = kdi_pkg::Digest;
          if (scrmbl_ready_i) begin
            ctrl.ent_clr = 1'b1;
            state_d      = FinSt;
          end
        end else if (scrmbl_ready_i) begin
          ctrl.ent_inc = 1'b1;
        end
      end
      FinSt: begin
        mtx_req_o      = 1'b1;
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = kdi_pkg::DigestFinalize;
        if (scrmbl_ready_i) begin
          state_d = WaitSt;
        end
      end
      // Result is one key half; after the first, start over from the IV
      WaitSt: begin
        mtx_req_o = 1'b1;
        if (scrmbl_rsp_valid_i) begin
          ctrl.key_en = 1'b1;
          if (ctrl.seed_cnt == 2'd1) begin
            ctrl.seed_inc = 1'b1;
            state_d       = ClrSt;
          end else begin
            ctrl.seed_clr      = 1'b1;
            ctrl.seed_valid_en = 1'b1;
            state_d            = FetchNonceSt;
          end
        end
      end
      // Mutex is released here
      FetchNonceSt: begin
        edn_req_d = 1'b1;
        if (edn_ack_i) begin
          ctrl.nonce_en = 1'b1;
          if (ctrl.ent_cnt == cfg_i.nonce_last) begin
            edn_req_d    = 1'b0;
            ctrl.ent_clr = 1'b1;
            state_d      = FinishSt;
          end else begin
            ctrl.ent_inc = 1'b1;
          end
        end
      end
      // Ack the requester through the arbiter
      FinishSt: begin
        ready_o = 1'b1;
        state_d = IdleSt;
      end
      // Terminal
      ErrorSt: begin
        fsm_err_o = 1'b1;
      end
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation wins over any other transition
    if (escalate_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ResetSt;
      edn_req_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      edn_req_q <= edn_req_d;
    end
  end

endmodule

// File: kdi_top.sv
/*
 * Scrambling-key derivation unit. Three requesters share one derivation
 * engine through a round-robin arbiter and an external digest engine
 */
`timescale 1ns/1ns

module kdi_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           kdi_en_i,
  input  logic                           escalate_i,
  // Requesters
  input  logic                           flash_data_req_i,
  input  logic                           flash_addr_req_i,
  input  logic                           sram_req_i,
  output logic                           flash_data_ack_o,
  output logic                           flash_addr_ack_o,
  output logic                           sram_ack_o,
  // Seeds from OTP
  input  logic                           seed_valid_i,
  input  logic [kdi_pkg::SeedWidth-1:0]  flash_data_seed_i,
  input  logic [kdi_pkg::SeedWidth-1:0]  flash_addr_seed_i,
  input  logic [kdi_pkg::KeyWidth-1:0]   sram_seed_i,
  // Results, shared by all requesters
  output logic [kdi_pkg::KeyWidth-1:0]   key_o,
  output logic [kdi_pkg::NonceWidth-1:0] nonce_o,
  output logic                           seed_valid_o,
  output logic                           fsm_err_o,
  // Entropy
  output logic                           edn_req_o,
  input  logic                           edn_ack_i,
  input  logic [kdi_pkg::EdnWidth-1:0]   edn_data_i,
  // Digest engine and its mutex
  output logic                           mtx_req_o,
  input  logic                           mtx_gnt_i,
  output logic                           scrmbl_valid_o,
  input  logic                           scrmbl_ready_i,
  output kdi_pkg::kdi_cmd_e              scrmbl_cmd_o,
  output kdi_pkg::kdi_sel_e              scrmbl_sel_o,
  output logic [kdi_pkg::BlockWidth-1:0] scrmbl_data_o,
  input  logic                           scrmbl_rsp_valid_i,
  input  logic [kdi_pkg::BlockWidth-1:0] scrmbl_rsp_data_i
);

  logic [kdi_pkg::NumReq-1:0] req;
  logic [kdi_pkg::NumReq-1:0] gnt;
  kdi_pkg::kdi_req_cfg_t      req_cfg [kdi_pkg::NumReq];
  kdi_pkg::kdi_req_cfg_t      cfg;
  logic                       req_valid;
  logic                       req_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Request mapping
  ////////////////////////////////////////////////////////////////////////////

  // Index order sets the round-robin order after reset
  assign req = {sram_req_i, flash_addr_req_i, flash_data_req_i};

  assign flash_data_ack_o = gnt[0];
  assign flash_addr_ack_o = gnt[1];
  assign sram_ack_o       = gnt[2];

  // Flash data key with a two-word nonce
  assign req_cfg[0] = '{ingest_entropy: 1'b0,
                        digest_sel:     kdi_pkg::FlashDataKey,
                        nonce_last:     2'd1,
                        seed_valid:     seed_valid_i,
                        seed:           flash_data_seed_i};
  // Flash address key, one nonce word only
  assign req_cfg[1] = '{ingest_entropy: 1'b0,
                        digest_sel:     kdi_pkg::FlashAddrKey,
                        nonce_last:     2'd0,
                        seed_valid:     seed_valid_i,
                        seed:           flash_addr_seed_i};
  // SRAM key mixes in entropy and uses its short seed for both halves
  assign req_cfg[2] = '{ingest_entropy: 1'b1,
                        digest_sel:     kdi_pkg::SramDataKey,
                        nonce_last:     2'd1,
                        seed_valid:     seed_valid_i,
                        seed:           {sram_seed_i, sram_seed_i}};

  ////////////////////////////////////////////////////////////////////////////
  // Arbiter, FSM and datapath
  ////////////////////////////////////////////////////////////////////////////

  kdi_ctrl_if u_ctrl_if ();

  kdi_req_arb #(
    .T (kdi_pkg::kdi_req_cfg_t)
  ) u_req_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req),
    .cfg_i   (req_cfg),
    .gnt_o   (gnt),
    .valid_o (req_valid),
    .cfg_o   (cfg),
    .ready_i (req_ready)
  );

  kdi_ctrl_fsm u_ctrl_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .kdi_en_i           (kdi_en_i),
    .escalate_i         (escalate_i),
    .valid_i            (req_valid),
    .cfg_i              (cfg),
    .ready_o            (req_ready),
    .ctrl               (u_ctrl_if),
    .edn_ack_i          (edn_ack_i),
    .edn_req_o          (edn_req_o),
    .mtx_gnt_i          (mtx_gnt_i),
    .mtx_req_o          (mtx_req_o),
    .scrmbl_ready_i     (scrmbl_ready_i),
    .scrmbl_rsp_valid_i (scrmbl_rsp_valid_i),
    .scrmbl_valid_o     (scrmbl_valid_o),
    .scrmbl_cmd_o       (scrmbl_cmd_o),
    .scrmbl_sel_o       (scrmbl_sel_o),
    .fsm_err_o          (fsm_err_o)
  );

  kdi_datapath u_datapath (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ctrl              (u_ctrl_if),
    .cfg_i             (cfg),
    .edn_data_i        (edn_data_i),
    .scrmbl_rsp_data_i (scrmbl_rsp_data_i),
    .scrmbl_data_o     (scrmbl_data_o),
    .key_o             (key_o),
    .nonce_o           (nonce_o),
    .seed_valid_o      (seed_valid_o)
  );

endmodule

// File: kdi_assert.sv
/*
 * Protocol checks on the digest, entropy, mutex and requester interfaces.
 * Bound into kdi_top by the testbench
 */
`timescale 1ns/1ns

module kdi_assert (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           esc_i,
  input logic                           err_i,
  input logic                           scrmbl_valid_i,
  input logic                           scrmbl_ready_i,
  input kdi_pkg::kdi_cmd_e              scrmbl_cmd_i,
  input logic [kdi_pkg::BlockWidth-1:0] scrmbl_data_i,
  input logic                           edn_req_i,
  input logic                           edn_ack_i,
  input logic                           mtx_gnt_i,
  input logic [kdi_pkg::NumReq-1:0]     ack_i
);

  // Number of failed assertions so far
  int fail_cnt = 0;

  // A stalled digest transfer keeps its command and data
  a_scrmbl_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || esc_i || err_i)
    scrmbl_valid_i && !scrmbl_ready_i |=>
      scrmbl_valid_i && $stable(scrmbl_cmd_i) && $stable(scrmbl_data_i))
    else begin
      $error("digest transfer dropped or changed before ready");
      fail_cnt++;
    end

  // Entropy request stays up until acked, error or not
  a_edn_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_i && !edn_ack_i |=> edn_req_i)
    else begin
      $error("entropy request dropped before ack");
      fail_cnt++;
    end

  // At most one requester acked per cycle
  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(ack_i))
    else begin
      $error("more than one requester acked in the same cycle");
      fail_cnt++;
    end

  // Terminal error never clears
  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_i |=> err_i)
    else begin
      $error("fsm error output dropped after being raised");
      fail_cnt++;
    end

  // Every digest transfer happens while the mutex is held
  a_scrmbl_mutex: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scrmbl_valid_i |-> mtx_gnt_i)
    else begin
      $error("digest transfer issued without mutex grant");
      fail_cnt++;
    end

endmodule

// File: tb_top.sv
/*
 * Testbench for kdi_top with digest engine, mutex and entropy models.
 * Runs the six derivation scenarios and prints a summary
 */
`timescale 1ns/1ns

module tb_top;

  // Cycle limit of every wait loop
  localparam int Timeout     = 400;
  // Window in which no ack may arrive
  localparam int QuietCycles = 40;

  logic         clk_i;
  logic         rst_ni       = 1'b0;
  logic         kdi_en_i     = 1'b0;
  logic         escalate_i   = 1'b0;
  logic [2:0]   req          = '0;
  logic [2:0]   ack;
  logic         seed_valid_i = 1'b0;
  logic [255:0] flash_data_seed = '0;
  logic [255:0] flash_addr_seed = '0;
  logic [127:0] sram_seed    = '0;
  logic [127:0] key_o;
  logic [127:0] nonce_o;
  logic         seed_valid_o;
  logic         fsm_err_o;
  // Model-driven inputs
  logic         edn_req_o;
  logic         edn_ack_i    = 1'b0;
  logic [63:0]  edn_data_i   = '0;
  logic         mtx_req_o;
  logic         mtx_gnt_i    = 1'b0;
  logic         scrmbl_valid_o;
  logic         scrmbl_ready_i = 1'b0;
  kdi_pkg::kdi_cmd_e scrmbl_cmd_o;
  kdi_pkg::kdi_sel_e scrmbl_sel_o;
  logic [63:0]  scrmbl_data_o;
  logic         scrmbl_rsp_valid_i = 1'b0;
  logic [63:0]  scrmbl_rsp_data_i  = '0;

  // Model state
  bit           bp_en = 1'b0;
  logic [63:0]  acc = '0;
  logic [63:0]  rsp_data = '0;
  int           rsp_cnt = 0;
  logic [63:0]  ent_log [$];
  // Requester whose derivation is expected on the digest engine
  int           cur_req = 0;

  int checks = 0;
  int errors = 0;
  int test_errs = 0;

  kdi_top u_dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .kdi_en_i (kdi_en_i), .escalate_i (escalate_i),
    .flash_data_req_i (req[0]), .flash_addr_req_i (req[1]), .sram_req_i (req[2]),
    .flash_data_ack_o (ack[0]), .flash_addr_ack_o (ack[1]), .sram_ack_o (ack[2]),
    .seed_valid_i (seed_valid_i), .flash_data_seed_i (flash_data_seed),
    .flash_addr_seed_i (flash_addr_seed), .sram_seed_i (sram_seed),
    .key_o (key_o), .nonce_o (nonce_o), .seed_valid_o (seed_valid_o), .fsm_err_o (fsm_err_o),
    .edn_req_o (edn_req_o), .edn_ack_i (edn_ack_i), .edn_data_i (edn_data_i),
    .mtx_req_o (mtx_req_o), .mtx_gnt_i (mtx_gnt_i),
    .scrmbl_valid_o (scrmbl_valid_o), .scrmbl_ready_i (scrmbl_ready_i),
    .scrmbl_cmd_o (scrmbl_cmd_o), .scrmbl_sel_o (scrmbl_sel_o),
    .scrmbl_data_o (scrmbl_data_o), .scrmbl_rsp_valid_i (scrmbl_rsp_valid_i),
    .scrmbl_rsp_data_i (scrmbl_rsp_data_i)
  );

  bind kdi_top kdi_assert u_assert (
    .clk_i (clk_i), .rst_ni (rst_ni), .esc_i (escalate_i), .err_i (fsm_err_o),
    .scrmbl_valid_i (scrmbl_valid_o), .scrmbl_ready_i (scrmbl_ready_i),
    .scrmbl_cmd_i (scrmbl_cmd_o), .scrmbl_data_i (scrmbl_data_o),
    .edn_req_i (edn_req_o), .edn_ack_i (edn_ack_i), .mtx_gnt_i (mtx_gnt_i),
    .ack_i ({sram_ack_o, flash_addr_ack_o, flash_data_ack_o})
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Digest engine, mutex and entropy models
  ////////////////////////////////////////////////////////////////////////////

  // Inputs change on the falling edge, transfers are predicted 1 ns later
  always @(negedge clk_i) begin : p_models
    if (!rst_ni) begin
      rsp_cnt = 0;
      acc     = '0;
    end
    scrmbl_rsp_valid_i = 1'b0;
    if (rsp_cnt > 0) begin
      rsp_cnt = rsp_cnt - 1;
      if (rsp_cnt == 0) begin
        scrmbl_rsp_valid_i = 1'b1;
        scrmbl_rsp_data_i  = rsp_data;
      end
    end
    scrmbl_ready_i = !bp_en || ($urandom % 4 != 0);
    // Grant is held for as long as it is requested
    mtx_gnt_i = mtx_req_o && (mtx_gnt_i || !bp_en || ($urandom % 4 == 0));
    edn_ack_i = edn_req_o && (!bp_en || ($urandom % 3 == 0));
    if (edn_ack_i) begin
      edn_data_i = {$urandom, $urandom};
      ent_log.push_back(edn_data_i);
    end
    #1;
    if (scrmbl_valid_o && scrmbl_ready_i) begin
      // Digest constants follow the requester being served
      check_value("scrmbl_sel_o", req_sel(cur_req), scrmbl_sel_o);
      case (scrmbl_cmd_o)
        kdi_pkg::DigestInit: acc = '0;
        kdi_pkg::DigestFinalize: begin
          rsp_cnt  = 1 + ($urandom % 3);
          rsp_data = acc;
        end
        default: acc = acc ^ scrmbl_data_o;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [63:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  // Flash data, flash address, then SRAM
  function automatic kdi_pkg::kdi_sel_e req_sel(input int idx);
    case (idx)
      0:       return kdi_pkg::FlashDataKey;
      1:       return kdi_pkg::FlashAddrKey;
      default: return kdi_pkg::SramDataKey;
    endcase
  endfunction

  // Each half is the XOR of its two seed blocks
  function automatic logic [127:0] flash_key(input logic [255:0] seed);
    return {seed[191:128] ^ seed[255:192], seed[63:0] ^ seed[127:64]};
  endfunction

  // SRAM halves also mix in the two entropy words of that half
  function automatic logic [127:0] sram_key(input logic [127:0] seed,
                                            input logic [63:0] e0, e1, e2, e3);
    logic [63:0] s;
    s = seed[63:0] ^ seed[127:64];
    return {s ^ e2 ^ e3, s ^ e0 ^ e1};
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, test_errs);
    end
    errors    = errors + test_errs;
    test_errs = 0;
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic enable_unit();
    kdi_en_i = 1'b1;
    @(negedge clk_i);
    kdi_en_i = 1'b0;
  endtask

  // Returns the index of the first ack seen, -1 on timeout
  task automatic wait_any_ack(output int idx);
    idx = -1;
    for (int cyc = 0; cyc < Timeout && idx < 0; cyc++) begin
      @(negedge clk_i);
      for (int i = 0; i < 3; i++) begin
        if (ack[i]) begin
          idx = i;
        end
      end
    end
    if (idx < 0) begin
      $display("Timeout: no requester was acked within %0d cycles", Timeout);
      test_errs++;
    end
  endtask

  // Raise one request, hold it until acked, then drop it
  task automatic run_request(input int idx);
    int got;
    ent_log.delete();
    cur_req  = idx;
    req[idx] = 1'b1;
    wait_any_ack(got);
    req[idx] = 1'b0;
    check_value("acked requester", idx, got);
  endtask

  // No ack may arrive, and the error output must stay at err
  task automatic quiet_window(input int cycles, input bit err);
    for (int cyc = 0; cyc < cycles; cyc++) begin
      @(negedge clk_i);
      check_value("ack", 3'b000, ack);
      check_value("fsm_err_o", err, fsm_err_o);
    end
  endtask

  task automatic check_flash_data();
    check_value("entropy words", 2, ent_log.size());
    check_value("key_o", flash_key(flash_data_seed), key_o);
    check_value("nonce_o", {ent_log[1], ent_log[0]}, nonce_o);
    check_value("seed_valid_o", 1'b1, seed_valid_o);
  endtask

  // Four ingested words, then two nonce words
  task automatic check_sram();
    check_value("entropy words", 6, ent_log.size());
    check_value("key_o", sram_key(sram_seed, ent_log[0], ent_log[1], ent_log[2],
                                  ent_log[3]), key_o);
    check_value("nonce_o", {ent_log[5], ent_log[4]}, nonce_o);
    check_value("seed_valid_o", 1'b1, seed_valid_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_main
    logic [127:0] exp_nonce;
    int           idx;
    int           fails;
    void'($urandom(1));
    apply_reset();

    // Held request is ignored until enable
    seed_valid_i    = 1'b1;
    flash_data_seed = {rand_word(), rand_word(), rand_word(), rand_word()};
    flash_addr_seed = {rand_word(), rand_word(), rand_word(), rand_word()};
    sram_seed       = {rand_word(), rand_word()};
    ent_log.delete();
    cur_req = 0;
    req[0]  = 1'b1;
    quiet_window(QuietCycles, 1'b0);
    enable_unit();
    wait_any_ack(idx);
    req[0] = 1'b0;
    check_value("acked requester", 0, idx);
    check_flash_data();
    exp_nonce = {ent_log[1], ent_log[0]};
    finish_test("1 enable and flash data key");

    // Invalid seed digests to zero, upper nonce word untouched
    seed_valid_i = 1'b0;
    run_request(1);
    check_value("entropy words", 1, ent_log.size());
    check_value("key_o", '0, key_o);
    check_value("nonce_o", {exp_nonce[127:64], ent_log[0]}, nonce_o);
    check_value("seed_valid_o", 1'b0, seed_valid_o);
    finish_test("2 flash address key, invalid seed");

    seed_valid_i = 1'b1;
    run_request(2);
    check_sram();
    finish_test("3 SRAM key with entropy");

    // Pointer starts at flash data after reset
    apply_reset();
    req     = 3'b111;
    cur_req = 0;
    enable_unit();
    for (int n = 0; n < 3; n++) begin
      cur_req = n;
      wait_any_ack(idx);
      check_value("ack order", n, idx);
      if (idx >= 0) begin
        req[idx] = 1'b0;
      end
    end
    req = '0;
    quiet_window(QuietCycles, 1'b0);
    finish_test("4 round-robin order");

    bp_en = 1'b1;
    run_request(0);
    check_flash_data();
    run_request(2);
    check_sram();
    bp_en = 1'b0;
    finish_test("5 back-pressure");

    // Escalate once the derivation holds the mutex
    cur_req = 2;
    req[2]  = 1'b1;
    idx     = 0;
    while (!mtx_req_o && idx < Timeout) begin
      @(negedge clk_i);
      idx++;
    end
    if (!mtx_req_o) begin
      $display("Timeout: derivation did not request the mutex");
      test_errs++;
    end
    escalate_i = 1'b1;
    @(negedge clk_i);
    escalate_i = 1'b0;
    quiet_window(QuietCycles, 1'b1);
    req[2] = 1'b0;
    finish_test("6 escalation");

    fails = u_dut.u_assert.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: list.f
kdi_pkg.sv
kdi_ctrl_if.sv
kdi_req_arb.sv
kdi_datapath.sv
kdi_ctrl_fsm.sv
kdi_top.sv
kdi_assert.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; passes only if the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f list.f || exit 1
out=$(./obj_dir/Vtb_top +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qxF "=== PASS ===" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
